//--- source/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int WORD_W = 32;
    localparam int ADDR_W = 8;
    localparam int SETS = 4;
    localparam int WAYS = 2;
    localparam int LINE_WORDS = 4;
    localparam int BEAT_WORDS = 2;
    localparam int BEATS_PER_LINE = LINE_WORDS / BEAT_WORDS;

    // address field widths, word addressed
    localparam int OFS_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFS_W;
    localparam int WAY_W = $clog2(WAYS);
    // memory beat addressing
    localparam int BEAT_ADDR_W = ADDR_W - $clog2(BEAT_WORDS);
    localparam int BEAT_CNT_W = $clog2(BEATS_PER_LINE);

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [OFS_W-1:0] ofs;
    } fetch_addr_t;

    // word address without the offset within the line
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
    } line_addr_t;

    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_data_t;
    typedef logic [BEAT_WORDS-1:0][WORD_W-1:0] beat_data_t;

    typedef struct packed {
        line_addr_t line;
    } refill_req_t;

    typedef struct packed {
        logic [BEAT_ADDR_W-1:0] beat;
    } mem_rd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
    } mem_wr_t;

    typedef enum logic [1:0] {IC_RESET, IC_READY, IC_MISS} icache_state_t;

endpackage

//--- source/inst_mem.sv
`timescale 1ns/1ps

module inst_mem (
    input  logic                   clk,
    input  logic                   mem_rd_valid,
    input  icache_pkg::mem_rd_t    mem_rd,
    output logic                   mem_rsp_valid,
    output icache_pkg::beat_data_t mem_rsp_data,
    input  logic                   mem_wr_valid,
    input  icache_pkg::mem_wr_t    mem_wr
);
    import icache_pkg::*;

    logic [WORD_W-1:0] mem_arr [2**ADDR_W];

    // preload, one word at a time
    always_ff @(posedge clk) begin
        if (mem_wr_valid) begin
            mem_arr[mem_wr.addr] <= mem_wr.data;
        end
    end

    // beat read, registered output
    always_ff @(posedge clk) begin
        mem_rsp_valid <= mem_rd_valid;
        if (mem_rd_valid) begin
            for (int b = 0; b < BEAT_WORDS; b++) begin
                mem_rsp_data[b] <= mem_arr[ADDR_W'(mem_rd.beat * BEAT_WORDS + b)];
            end
        end
    end

endmodule

//--- source/line_refill.sv
`timescale 1ns/1ps

module line_refill (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    refill_valid,
    input  icache_pkg::refill_req_t refill_req,
    output logic                    refill_ready,
    output logic                    mem_rd_valid,
    output icache_pkg::mem_rd_t     mem_rd,
    input  logic                    mem_rsp_valid,
    input  icache_pkg::beat_data_t  mem_rsp_data,
    output logic                    fill_valid,
    output icache_pkg::line_data_t  fill_data
);
    import icache_pkg::*;

    logic                  busy;
    logic                  rd_active;
    logic [BEAT_CNT_W-1:0] rd_cnt;
    logic [BEAT_CNT_W-1:0] rsp_cnt;
    line_addr_t            line_q;
    line_data_t            line_buf;
    logic                  accept;
    logic                  last_rsp;

    assign refill_ready = !busy;
    assign accept = refill_valid && refill_ready;
    assign last_rsp = mem_rsp_valid && (rsp_cnt == BEAT_CNT_W'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            rd_active <= 1'b0;
            rd_cnt <= '0;
            rsp_cnt <= '0;
            fill_valid <= 1'b0;
        end else begin
            // busy until the assembled line has been handed over
            if (accept) begin
                busy <= 1'b1;
            end else if (fill_valid) begin
                busy <= 1'b0;
            end
            if (accept) begin
                rd_active <= 1'b1;
                rd_cnt <= '0;
            end else if (rd_active) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == BEAT_CNT_W'(BEATS_PER_LINE - 1)) begin
                    rd_active <= 1'b0;
                end
            end
            if (mem_rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end
            fill_valid <= last_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            line_q <= refill_req.line;
        end
        if (mem_rsp_valid) begin
            line_buf[rsp_cnt * BEAT_WORDS +: BEAT_WORDS] <= mem_rsp_data;
        end
    end

    // beats of a line are contiguous and aligned
    assign mem_rd_valid = rd_active;
    assign mem_rd = '{beat: {line_q, rd_cnt}};
    assign fill_data = line_buf;

    a_rsp_while_busy: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> busy)
        else $error("memory beat with no refill in progress");

    a_fill_pulse: assert property (@(posedge clk) disable iff (rst)
        fill_valid |=> !fill_valid)
        else $error("fill_valid held longer than one cycle");

endmodule

//--- source/icache_core.sv
`timescale 1ns/1ps

module icache_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        core_req_valid,
    input  icache_pkg::fetch_addr_t     core_req,
    output logic                        core_req_ready,
    output logic                        core_rsp_valid,
    output logic [icache_pkg::WORD_W-1:0] core_rsp_data,
    output logic                        refill_valid,
    output icache_pkg::refill_req_t     refill_req,
    input  logic                        refill_ready,
    input  logic                        fill_valid,
    input  icache_pkg::line_data_t      fill_data
);
    import icache_pkg::*;

    // line arrays, indexed [way][set]
    logic               valid_arr [WAYS][SETS];
    logic [TAG_W-1:0]   tag_arr   [WAYS][SETS];
    line_data_t         data_arr  [WAYS][SETS];
    logic [WAY_W-1:0]   lru_arr   [WAYS][SETS];

    icache_state_t state, state_nx;

    logic               req_fire;
    logic               lookup_hit;
    logic [WAY_W-1:0]   lookup_way;
    logic [WAY_W-1:0]   victim_way;

    // request accepted in the previous cycle
    logic               req_valid_q;
    logic               hit_q;
    fetch_addr_t        req_q;
    logic [WAY_W-1:0]   way_q;

    // miss waiting for its line
    logic               pend_valid;
    fetch_addr_t        pend_addr;
    logic [WAY_W-1:0]   pend_way;

    logic               fill_take;
    logic               fill_done_q;
    logic               lru_upd;
    logic [IDX_W-1:0]   upd_idx;
    logic [WAY_W-1:0]   upd_way;
    logic [WAY_W-1:0]   rsp_way;

    assign req_fire = core_req_valid && core_req_ready;
    assign fill_take = (state == IC_MISS) && fill_valid;

    // tag search over all ways, victim is the way with the oldest counter
    always_comb begin
        lookup_hit = 1'b0;
        lookup_way = '0;
        victim_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_arr[w][core_req.idx] && (tag_arr[w][core_req.idx] == core_req.tag)) begin
                lookup_hit = 1'b1;
                lookup_way = WAY_W'(w);
            end
            if (lru_arr[w][core_req.idx] == WAY_W'(WAYS - 1)) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
            hit_q <= 1'b0;
            fill_done_q <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            req_valid_q <= req_fire;
            hit_q <= lookup_hit;
            fill_done_q <= fill_take;
            if (req_fire && !lookup_hit) begin
                pend_valid <= 1'b1;
            end else if (fill_done_q) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q <= core_req;
            way_q <= lookup_way;
        end
        if (req_fire && !lookup_hit) begin
            pend_addr <= core_req;
            pend_way <= victim_way;
        end
    end

    // line fill
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    valid_arr[w][s] <= 1'b0;
                end
            end
        end else if (fill_take) begin
            valid_arr[pend_way][pend_addr.idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_take) begin
            tag_arr[pend_way][pend_addr.idx] <= pend_addr.tag;
            data_arr[pend_way][pend_addr.idx] <= fill_data;
        end
    end

    // hits and fills never share a cycle, so one update port is enough
    assign lru_upd = (req_fire && lookup_hit) || fill_take;
    assign upd_idx = fill_take ? pend_addr.idx : core_req.idx;
    assign upd_way = fill_take ? pend_way : lookup_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    lru_arr[w][s] <= WAY_W'(w);
                end
            end
        end else if (lru_upd) begin
            for (int w = 0; w < WAYS; w++) begin
                if (lru_arr[w][upd_idx] < lru_arr[upd_way][upd_idx]) begin
                    lru_arr[w][upd_idx] <= lru_arr[w][upd_idx] + 1'b1;
                end
            end
            lru_arr[upd_way][upd_idx] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IC_RESET;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            IC_RESET: state_nx = IC_READY;
            IC_READY: begin
                if (refill_valid && refill_ready) begin
                    state_nx = IC_MISS;
                end
            end
            IC_MISS: begin
                if (fill_valid) begin
                    state_nx = IC_READY;
                end
            end
            default: state_nx = IC_RESET;
        endcase
    end

    // ready stays low from the miss until its response goes out
    assign core_req_ready = (state == IC_READY) && (!pend_valid || fill_done_q);
    assign refill_valid = (state == IC_READY) && pend_valid && !fill_done_q;
    assign refill_req = '{line: '{tag: pend_addr.tag, idx: pend_addr.idx}};

    // the missed request is still held in req_q, only its way comes from the fill
    assign rsp_way = fill_done_q ? pend_way : way_q;
    assign core_rsp_valid = fill_done_q || (req_valid_q && hit_q);
    assign core_rsp_data = data_arr[rsp_way][req_q.idx][req_q.ofs];

    a_no_rsp_in_miss: assert property (@(posedge clk) disable iff (rst)
        (state == IC_MISS) |-> !core_rsp_valid)
        else $error("response while waiting for a line");

    a_refill_has_pend: assert property (@(posedge clk) disable iff (rst)
        $rose(refill_valid) |-> $past(req_fire && !lookup_hit))
        else $error("refill request without a pending miss");

endmodule

//--- source/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          core_req_valid,
    input  icache_pkg::fetch_addr_t       core_req,
    output logic                          core_req_ready,
    output logic                          core_rsp_valid,
    output logic [icache_pkg::WORD_W-1:0] core_rsp_data,
    input  logic                          mem_wr_valid,
    input  icache_pkg::mem_wr_t           mem_wr
);
    import icache_pkg::*;

    // cache to refill unit
    logic        refill_valid;
    logic        refill_ready;
    refill_req_t refill_req;
    logic        fill_valid;
    line_data_t  fill_data;

    // refill unit to memory
    logic        mem_rd_valid;
    mem_rd_t     mem_rd;
    logic        mem_rsp_valid;
    beat_data_t  mem_rsp_data;

    icache_core i_icache_core (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_data  (core_rsp_data),
        .refill_valid   (refill_valid),
        .refill_req     (refill_req),
        .refill_ready   (refill_ready),
        .fill_valid     (fill_valid),
        .fill_data      (fill_data)
    );

    line_refill i_line_refill (
        .clk           (clk),
        .rst           (rst),
        .refill_valid  (refill_valid),
        .refill_req    (refill_req),
        .refill_ready  (refill_ready),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd        (mem_rd),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .fill_valid    (fill_valid),
        .fill_data     (fill_data)
    );

    inst_mem i_inst_mem (
        .clk           (clk),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd        (mem_rd),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_wr_valid  (mem_wr_valid),
        .mem_wr        (mem_wr)
    );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held over the first 8 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int NUM_FETCH = 417;
    localparam int MISS_CYCLES = 6;
    localparam int MAX_CYCLES = NUM_FETCH * (MISS_CYCLES + 2) + 2**ADDR_W + 200;

    typedef struct packed {
        fetch_addr_t       addr;
        logic [WORD_W-1:0] word;
        logic              hit;
        logic [31:0]       cycle;
    } expect_t;

    logic              clk;
    logic              rst;
    logic              core_req_valid;
    fetch_addr_t       core_req;
    logic              core_req_ready;
    logic              core_rsp_valid;
    logic [WORD_W-1:0] core_rsp_data;
    logic              mem_wr_valid;
    mem_wr_t           mem_wr;

    // reference memory and cache state
    logic [WORD_W-1:0] mem_model [2**ADDR_W];
    logic              model_valid [WAYS][SETS];
    logic [TAG_W-1:0]  model_tag [WAYS][SETS];
    line_data_t        model_line [WAYS][SETS];
    int                model_age [WAYS][SETS];

    expect_t     pending[$];
    logic [31:0] cycle = '0;
    int          fail_count = 0;
    int          rsp_count = 0;
    string       test_name = "init";

    clock_gen i_clock_gen (.clk(clk), .rst(rst));

    icache_top i_icache_top (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_data  (core_rsp_data),
        .mem_wr_valid   (mem_wr_valid),
        .mem_wr         (mem_wr)
    );

    task automatic stop_on_error(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input fetch_addr_t addr, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s: word at %h expected %h, actual %h",
                                    test_name, addr, exp, act));
        end
    endtask

    task automatic check_hit(input fetch_addr_t addr, input bit exp, input bit act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s: hit at %h expected %0b, actual %0b",
                                    test_name, addr, exp, act));
        end
    endtask

    task automatic clear_model();
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                model_valid[w][s] = 1'b0;
                model_age[w][s] = w;
            end
        end
    endtask

    // what the cache returns, with lru ages and captured lines updated
    function automatic logic [WORD_W-1:0] expected_word(input fetch_addr_t a, output bit hit);
        int way;
        int used_age;
        int base;
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[w][a.idx] && model_tag[w][a.idx] == a.tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = 0; w < WAYS; w++) begin
                if (model_age[w][a.idx] == WAYS - 1) way = w;
            end
            base = int'({a.tag, a.idx}) * LINE_WORDS;
            model_valid[way][a.idx] = 1'b1;
            model_tag[way][a.idx] = a.tag;
            for (int k = 0; k < LINE_WORDS; k++) begin
                model_line[way][a.idx][k] = mem_model[base + k];
            end
        end
        used_age = model_age[way][a.idx];
        for (int w = 0; w < WAYS; w++) begin
            if (model_age[w][a.idx] < used_age) model_age[w][a.idx]++;
        end
        model_age[way][a.idx] = 0;
        return model_line[way][a.idx][a.ofs];
    endfunction

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        mem_wr_valid = 1'b1;
        mem_wr = '{addr: addr, data: data};
        mem_model[addr] = data;
        @(negedge clk);
        mem_wr_valid = 1'b0;
    endtask

    // holds the request until ready, ready only moves on a rising edge
    task automatic issue(input logic [ADDR_W-1:0] raw);
        fetch_addr_t a;
        expect_t     e;
        bit          hit;
        a = raw;
        core_req_valid = 1'b1;
        core_req = a;
        while (core_req_ready !== 1'b1) @(negedge clk);
        e.addr = a;
        e.cycle = cycle;
        e.word = expected_word(a, hit);
        e.hit = hit;
        pending.push_back(e);
        @(negedge clk);
    endtask

    task automatic idle_cycle();
        core_req_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic drain();
        core_req_valid = 1'b0;
        while (pending.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic fetch_one(input logic [ADDR_W-1:0] raw);
        issue(raw);
        drain();
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == MAX_CYCLES) begin
            stop_on_error($sformatf("timeout: run did not end within %0d cycles", MAX_CYCLES));
        end
    end

    // responses come back in request order
    always @(negedge clk) begin
        expect_t e;
        if (!rst && core_rsp_valid === 1'b1) begin
            if (pending.size() == 0) begin
                stop_on_error("response arrived with no request outstanding");
            end else begin
                e = pending.pop_front();
                check_word(e.addr, e.word, core_rsp_data);
                check_hit(e.addr, e.hit, cycle == e.cycle + 1);
                rsp_count++;
            end
        end
    end

    initial begin
        logic [ADDR_W-1:0] raw;
        logic [31:0]       c0;
        int                tries;
        void'($urandom(32'h13e16a26));
        core_req_valid = 1'b0;
        core_req = '0;
        mem_wr_valid = 1'b0;
        mem_wr = '0;
        clear_model();

        test_name = "reset";
        @(posedge clk);
        while (rst) begin
            @(negedge clk);
            if (core_req_ready !== 1'b0 || core_rsp_valid !== 1'b0) begin
                stop_on_error("ready or response not low during reset");
            end
            @(posedge clk);
        end
        @(negedge clk);
        tries = 0;
        while (core_req_ready !== 1'b1) begin
            if (tries == 4) stop_on_error("ready did not rise after reset");
            tries++;
            @(negedge clk);
        end

        test_name = "cold_miss";
        for (int i = 0; i < 2**ADDR_W; i++) begin
            write_word(ADDR_W'(i), $urandom());
        end
        fetch_one(8'h00);
        fetch_one(8'h14);
        fetch_one(8'h2b);
        fetch_one(8'h3e);

        // rest of line 0x00, one hit per cycle
        test_name = "hit_stream";
        c0 = cycle;
        issue(8'h01);
        issue(8'h02);
        issue(8'h03);
        if (cycle - c0 != 3) stop_on_error("hits did not stream at one per cycle");
        drain();

        // set 0 with lines A, B and C
        test_name = "lru";
        fetch_one(8'h10);
        fetch_one(8'h20);
        fetch_one(8'h10);
        fetch_one(8'h30);
        fetch_one(8'h10);
        fetch_one(8'h20);

        test_name = "no_coherence";
        write_word(8'h11, ~mem_model[8'h11]);
        fetch_one(8'h11);
        fetch_one(8'h30);
        fetch_one(8'h20);
        fetch_one(8'h11);

        test_name = "random";
        for (int i = 0; i < 400; i++) begin
            raw = ADDR_W'($urandom_range(0, 63));
            issue(raw);
            if ($urandom_range(0, 3) == 0) idle_cycle();
        end
        drain();
        $display("%0d responses checked", rsp_count);

        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
source/icache_pkg.sv
source/inst_mem.sv
source/line_refill.sv
source/icache_core.sv
source/icache_top.sv
bench/clock_gen.sv
bench/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
